/* verilog/can_pkg.sv */
package can_pkg;

	// ============================================================
	// Frame field lengths
	// ============================================================

	localparam int unsigned len_id_a = 11;          // Base identifier
	localparam int unsigned len_id_b = 18;          // Identifier extension
	localparam int unsigned len_dlc = 4;
	localparam int unsigned len_crc = 15;
	localparam int unsigned len_eof = 7;

	// Third intermission bit may already be the next start of frame
	localparam int unsigned len_intermission = 2;

	localparam int unsigned len_stuff_run = 5;      // Equal bits before a stuff bit
	localparam int unsigned len_recovery = 11;      // Recessive bits ending error recovery
	localparam int unsigned max_data_bytes = 8;     // DLC values above 8 read as 8

	// x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
	localparam logic [14:0] crc_polynomial = 15'h4599;

	// ============================================================
	// Parser states in bus order
	// ============================================================

	typedef enum logic [4:0] {
		idle          = 5'd0,
		id_a          = 5'd1,   // First stuffed field
		srr_rtr       = 5'd2,   // SRR or RTR, known only after IDE
		ide           = 5'd3,
		id_b          = 5'd4,
		rtr           = 5'd5,
		reserved1     = 5'd6,
		reserved0     = 5'd7,
		dlc           = 5'd8,
		data          = 5'd9,   // Last field in the CRC
		crc           = 5'd10,  // Last stuffed field
		crc_delimiter = 5'd11,
		ack_slot      = 5'd12,
		ack_delimiter = 5'd13,
		eof           = 5'd14,
		intermission  = 5'd15,
		recovery      = 5'd16
	} parser_state_t;

	typedef enum logic [1:0] {
		error_stuff = 2'd0,
		error_form  = 2'd1,
		error_crc   = 2'd2,
		error_ack   = 2'd3
	} error_kind_t;

	// Identifier word, base part sent first
	typedef struct packed {
		logic [len_id_a-1:0] base;
		logic [len_id_b-1:0] ext;    // Zero in base frames
	} can_id_parts_t;

	typedef union packed {
		logic [len_id_a+len_id_b-1:0] full;    // 29-bit extended identifier
		can_id_parts_t part;
	} can_id_t;

endpackage

/* verilog/can_destuffer.sv */
module can_destuffer (
	input  logic clock,
	input  logic reset,
	input  logic rx_bit,
	input  logic sample_point,
	input  logic stuff_enable,     // High over the stuffed fields
	output logic bit_valid,
	output logic bit_value,
	output logic stuff_error
);

	// ============================================================
	// Bit history
	// ============================================================

	logic [can_pkg::len_stuff_run-1:0] history;    // Newest bit in LSB
	logic run_equal;                                // Last five bits identical
	logic stuff_bit;

	// Every sampled bit enters, stuff bits too
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			history <= 5'b10101;    // Alternating, no run at start
		else if (sample_point)
			history <= {history[can_pkg::len_stuff_run-2:0], rx_bit};
	end

	// ============================================================
	// Stuff detection
	// ============================================================

	assign run_equal = (&history) | ~(|history);

	// Opposite level after a run
	assign stuff_bit = sample_point & stuff_enable & run_equal & (rx_bit != history[0]);

	// Sixth equal bit
	assign stuff_error = sample_point & stuff_enable & run_equal & (rx_bit == history[0]);

	assign bit_valid = sample_point & ~stuff_bit;   // Stuff bits dropped
	assign bit_value = rx_bit;

endmodule

/* verilog/can_crc15.sv */
module can_crc15 (
	input  logic        clock,
	input  logic        reset,
	input  logic        crc_clear,    // Held while parser idles
	input  logic        crc_shift,    // One destuffed bit
	input  logic        bit_value,
	output logic [14:0] crc_value
);

	logic feedback;

	// Incoming bit against the MSB
	assign feedback = bit_value ^ crc_value[14];

	// ============================================================
	// CRC-15 shift register
	// ============================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_value <= '0;
		else if (crc_clear)
			crc_value <= '0;
		else if (crc_shift)
		begin
			if (feedback)
				crc_value <= {crc_value[13:0], 1'b0} ^ can_pkg::crc_polynomial;
			else
				crc_value <= {crc_value[13:0], 1'b0};
		end
	end

endmodule

/* verilog/can_frame_parser.sv */
module can_frame_parser (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   rx_bit,         // Raw level for unstuffed fields
	input  logic                   sample_point,
	input  logic                   bit_valid,      // Destuffed bit strobe
	input  logic                   bit_value,
	input  logic                   stuff_error,
	input  logic [14:0]            crc_value,      // Locally computed CRC
	output logic                   stuff_enable,
	output logic                   crc_clear,
	output logic                   crc_shift,
	output logic                   frame_valid,
	output logic                   frame_error,
	output can_pkg::error_kind_t   error_kind,
	output can_pkg::can_id_t       can_id,
	output logic                   extended,
	output logic                   remote,
	output logic [3:0]             dlc,
	output logic [8*can_pkg::max_data_bytes-1:0] data
);

	can_pkg::parser_state_t state;
	can_pkg::parser_state_t state_next;
	can_pkg::error_kind_t error_code;

	logic [5:0] bit_count;              // Shared by every field
	logic stuffed_field;
	logic count_step;                   // Current field takes a bit
	logic count_clear;
	logic sof;
	logic frame_done;
	logic error_hit;
	logic srr_rtr_bit;                  // Held until IDE tells SRR from RTR
	logic [can_pkg::len_crc-1:0] crc_rx;
	logic [3:0] dlc_shifted;
	logic [3:0] dlc_capped;
	logic [6:0] data_last;              // Index of the last data bit

	// ============================================================
	// Strobes toward destuffer and CRC
	// ============================================================

	assign stuffed_field = (state >= can_pkg::id_a) && (state <= can_pkg::crc);
	assign stuff_enable = stuffed_field;
	assign crc_clear = (state == can_pkg::idle);
	assign crc_shift = bit_valid && (state >= can_pkg::id_a) && (state <= can_pkg::data);

	assign count_step = stuffed_field ? bit_valid : sample_point;
	assign sof = (state == can_pkg::idle) && sample_point && !rx_bit;

	assign dlc_shifted = {dlc[2:0], bit_value};    // DLC with the incoming bit
	assign dlc_capped = (dlc > can_pkg::max_data_bytes) ? 4'(can_pkg::max_data_bytes) : dlc;
	assign data_last = {dlc_capped, 3'b000} - 7'd1;

	// ============================================================
	// Next state and error detection
	// ============================================================

	always_comb
	begin
		state_next = state;
		error_hit = 1'b0;
		error_code = can_pkg::error_form;
		frame_done = 1'b0;
		count_clear = 1'b0;
		if (stuffed_field && stuff_error)
		begin
			error_hit = 1'b1;
			error_code = can_pkg::error_stuff;
		end
		else if (count_step)
		begin
			case (state)
			can_pkg::idle:
				if (!rx_bit)
					state_next = can_pkg::id_a;    // Start of frame
			can_pkg::id_a:
				if (bit_count == can_pkg::len_id_a - 1)
					state_next = can_pkg::srr_rtr;
			can_pkg::srr_rtr:
				state_next = can_pkg::ide;
			can_pkg::ide:
				if (bit_value && !srr_rtr_bit)
					error_hit = 1'b1;              // Dominant SRR
				else if (bit_value)
					state_next = can_pkg::id_b;
				else
					state_next = can_pkg::reserved0;
			can_pkg::id_b:
				if (bit_count == can_pkg::len_id_b - 1)
					state_next = can_pkg::rtr;
			can_pkg::rtr:
				state_next = can_pkg::reserved1;
			can_pkg::reserved1:
				state_next = can_pkg::reserved0;
			can_pkg::reserved0:
				state_next = can_pkg::dlc;
			can_pkg::dlc:
				if (bit_count == can_pkg::len_dlc - 1)
				begin
					// Remote frames and DLC 0 carry no data
					if (remote || dlc_shifted == 4'd0)
						state_next = can_pkg::crc;
					else
						state_next = can_pkg::data;
				end
			can_pkg::data:
				if ({1'b0, bit_count} == data_last)
					state_next = can_pkg::crc;
			can_pkg::crc:
				if (bit_count == can_pkg::len_crc - 1)
					state_next = can_pkg::crc_delimiter;
			can_pkg::crc_delimiter:
				if (!rx_bit)
					error_hit = 1'b1;
				else
					state_next = can_pkg::ack_slot;
			can_pkg::ack_slot:
				if (rx_bit)
				begin
					error_hit = 1'b1;              // No receiver acknowledged
					error_code = can_pkg::error_ack;
				end
				else
					state_next = can_pkg::ack_delimiter;
			can_pkg::ack_delimiter:
				if (crc_rx != crc_value)
				begin
					error_hit = 1'b1;
					error_code = can_pkg::error_crc;
				end
				else if (!rx_bit)
					error_hit = 1'b1;
				else
					state_next = can_pkg::eof;
			can_pkg::eof:
				if (!rx_bit)
					error_hit = 1'b1;
				else if (bit_count == can_pkg::len_eof - 1)
				begin
					frame_done = 1'b1;
					state_next = can_pkg::intermission;
				end
			can_pkg::intermission:
				if (!rx_bit)
					error_hit = 1'b1;
				else if (bit_count == can_pkg::len_intermission - 1)
					state_next = can_pkg::idle;
			can_pkg::recovery:
				if (!rx_bit)
					count_clear = 1'b1;            // Run of recessive bits broken
				else if (bit_count == can_pkg::len_recovery - 1)
					state_next = can_pkg::idle;
			default:
				state_next = can_pkg::idle;
			endcase
		end
		if (error_hit)
			state_next = can_pkg::recovery;
	end

	// ============================================================
	// State, bit counter and strobes
	// ============================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= can_pkg::idle;
			bit_count <= '0;
			frame_valid <= 1'b0;
			frame_error <= 1'b0;
			error_kind <= can_pkg::error_stuff;
		end
		else
		begin
			state <= state_next;
			frame_valid <= frame_done;
			frame_error <= error_hit;
			if (error_hit)
				error_kind <= error_code;          // Kept until the next error
			if (state_next != state || count_clear)
				bit_count <= '0;                   // Each field counts from zero
			else if (count_step)
				bit_count <= bit_count + 6'd1;
		end
	end

	// ============================================================
	// Frame fields
	// ============================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			can_id <= '0;
			extended <= 1'b0;
			remote <= 1'b0;
			dlc <= '0;
			data <= '0;
		end
		else if (sof)
		begin
			can_id <= '0;
			extended <= 1'b0;
			remote <= 1'b0;
			dlc <= '0;
			data <= '0;
		end
		else if (bit_valid)
		begin
			case (state)
			can_pkg::id_a:
				can_id.part.base <= {can_id.part.base[can_pkg::len_id_a-2:0], bit_value};
			can_pkg::ide:
			begin
				extended <= bit_value;
				if (!bit_value)
					remote <= srr_rtr_bit;         // Base frame RTR
			end
			can_pkg::id_b:
				can_id.part.ext <= {can_id.part.ext[can_pkg::len_id_b-2:0], bit_value};
			can_pkg::rtr:
				remote <= bit_value;               // Extended frame RTR
			can_pkg::dlc:
				dlc <= dlc_shifted;
			can_pkg::data:
				data <= {data[8*can_pkg::max_data_bytes-2:0], bit_value};
			default:
				;
			endcase
		end
	end

	// Bits consumed by the parser only
	always_ff @(posedge clock)
	begin
		if (bit_valid && state == can_pkg::srr_rtr)
			srr_rtr_bit <= bit_value;
		if (bit_valid && state == can_pkg::crc)
			crc_rx <= {crc_rx[can_pkg::len_crc-2:0], bit_value};
	end

endmodule

/* verilog/can_decoder.sv */
module can_decoder (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   rx_bit,         // 1 is recessive
	input  logic                   sample_point,
	output logic                   frame_valid,
	output logic                   frame_error,
	output can_pkg::error_kind_t   error_kind,
	output can_pkg::can_id_t       can_id,
	output logic                   extended,
	output logic                   remote,
	output logic [3:0]             dlc,
	output logic [8*can_pkg::max_data_bytes-1:0] data
);

	logic bit_valid;
	logic bit_value;
	logic stuff_error;
	logic stuff_enable;
	logic crc_clear;
	logic crc_shift;
	logic [14:0] crc_value;

	// ============================================================
	// Destuffer feeding CRC and parser
	// ============================================================

	can_destuffer u_destuffer (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.stuff_enable (stuff_enable),
		.bit_valid    (bit_valid),
		.bit_value    (bit_value),
		.stuff_error  (stuff_error)
	);

	can_crc15 u_crc15 (
		.clock     (clock),
		.reset     (reset),
		.crc_clear (crc_clear),
		.crc_shift (crc_shift),
		.bit_value (bit_value),
		.crc_value (crc_value)
	);

	can_frame_parser u_parser (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.bit_valid    (bit_valid),
		.bit_value    (bit_value),
		.stuff_error  (stuff_error),
		.crc_value    (crc_value),
		.stuff_enable (stuff_enable),
		.crc_clear    (crc_clear),
		.crc_shift    (crc_shift),
		.frame_valid  (frame_valid),
		.frame_error  (frame_error),
		.error_kind   (error_kind),
		.can_id       (can_id),
		.extended     (extended),
		.remote       (remote),
		.dlc          (dlc),
		.data         (data)
	);

endmodule

/* test/can_clock_gen.sv */
module can_clock_gen #(
	parameter int period = 20    // Clock period in time units
) (
	output logic clock
);

	initial
	begin
		clock = 1'b0;
	end

	// Free-running, first rising edge at half a period
	always #(period / 2) clock = ~clock;

endmodule

/* test/can_frame_model.svh */
`ifndef can_frame_model_svh
`define can_frame_model_svh

// ============================================================
// Frame bit lists
// ============================================================

localparam int corrupt_none = 0;
localparam int corrupt_stuff = 1;    // Six dominant bits in the identifier
localparam int corrupt_crc = 2;      // One CRC bit flipped
localparam int corrupt_ack = 3;      // Nobody drives the ACK slot

logic raw_bits[$];     // SOF through CRC, before stuffing
logic line_bits[$];    // Bus levels in sending order

// MSB first, as on the bus
task automatic push_field(input logic [63:0] value, input int width);
	int i;
	for (i = width - 1; i >= 0; i--)
		raw_bits.push_back(value[i]);
endtask

// CAN CRC-15, x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
function automatic logic [14:0] crc_of_bits();
	logic [14:0] reg_value;
	logic next_bit;
	int i;
	reg_value = '0;
	for (i = 0; i < raw_bits.size(); i++)
	begin
		next_bit = raw_bits[i] ^ reg_value[14];
		reg_value = {reg_value[13:0], 1'b0};
		if (next_bit)
			reg_value = reg_value ^ 15'h4599;
	end
	return reg_value;
endfunction

// Stuff bit goes in ahead of the next field bit after five equal ones
task automatic stuff_bits();
	int i;
	int run;
	logic last;
	line_bits.delete();
	run = 0;
	last = 1'b1;
	for (i = 0; i < raw_bits.size(); i++)
	begin
		if (run == 5)
		begin
			line_bits.push_back(~last);    // Stuff bit starts a new run
			last = ~last;
			run = 1;
		end
		if (run > 0 && raw_bits[i] == last)
			run++;
		else
		begin
			run = 1;
			last = raw_bits[i];
		end
		line_bits.push_back(raw_bits[i]);
	end
endtask

// Six dominant bits ahead of line position
task automatic inject_dominant_run(input int position);
	logic held_bits[$];
	int i;
	held_bits = line_bits;
	line_bits.delete();
	for (i = 0; i < held_bits.size(); i++)
	begin
		if (i == position)
			repeat (6) line_bits.push_back(1'b0);
		line_bits.push_back(held_bits[i]);
	end
endtask

task automatic build_frame(input logic ext, input logic rem, input logic [28:0] id,
	input logic [3:0] dlc_code, input logic [63:0] payload, input int corruption);
	logic [14:0] crc_word;
	int nbytes;
	raw_bits.delete();
	raw_bits.push_back(1'b0);                 // SOF
	if (ext)
	begin
		push_field(id[28:18], 11);
		push_field(2'b11, 2);                 // SRR, IDE
		push_field(id[17:0], 18);
		push_field(rem, 1);                   // RTR
		push_field(2'b00, 2);                 // r1, r0
	end
	else
	begin
		push_field(id[10:0], 11);
		push_field(rem, 1);
		push_field(2'b00, 2);                 // IDE, r0
	end
	push_field(dlc_code, 4);
	nbytes = (dlc_code > 8) ? 8 : dlc_code;
	if (!rem)
		push_field(payload, 8 * nbytes);      // No data field in remote frames
	crc_word = crc_of_bits();
	if (corruption == corrupt_crc)
		crc_word[6] = ~crc_word[6];
	push_field(crc_word, 15);
	stuff_bits();
	if (corruption == corrupt_stuff)
		inject_dominant_run(3);               // Inside the base identifier
	line_bits.push_back(1'b1);                // CRC delimiter
	line_bits.push_back(corruption == corrupt_ack);
	repeat (8) line_bits.push_back(1'b1);     // ACK delimiter and EOF
	if (corruption == corrupt_none)
		repeat (3) line_bits.push_back(1'b1); // Intermission
	else
		repeat (11) line_bits.push_back(1'b1);
endtask

`endif

/* test/can_decoder_tb.sv */
module can_decoder_tb;

	localparam int rows = 7;
	localparam int cycle_limit = rows * 200 * 4 + 100;   // 200 bits of 4 clocks per row

	localparam int outcome_frame = 0;
	localparam int outcome_stuff = 1;
	localparam int outcome_crc = 2;
	localparam int outcome_ack = 3;

	logic clock;
	logic reset;
	logic rx_bit;
	logic sample_point;
	logic frame_valid;
	logic frame_error;
	can_pkg::error_kind_t error_kind;
	can_pkg::can_id_t can_id;
	logic extended;
	logic remote;
	logic [3:0] dlc;
	logic [63:0] data;

	// Stimulus table, one entry per test
	logic row_ext [0:rows-1];
	logic row_rem [0:rows-1];
	logic [28:0] row_id [0:rows-1];
	logic [3:0] row_dlc [0:rows-1];
	logic row_random [0:rows-1];     // Draw the data instead
	logic [63:0] row_data [0:rows-1];
	int row_corrupt [0:rows-1];
	int row_outcome [0:rows-1];

	integer seed;
	int cycle_count;
	int valid_seen;
	int error_seen;
	can_pkg::error_kind_t seen_kind;
	logic row_failed;
	int pass_count;
	int fail_count;
	int row;

	`include "can_frame_model.svh"

	can_clock_gen #(.period(20)) u_clock_gen (.clock(clock));

	can_decoder dut (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.frame_valid  (frame_valid),
		.frame_error  (frame_error),
		.error_kind   (error_kind),
		.can_id       (can_id),
		.extended     (extended),
		.remote       (remote),
		.dlc          (dlc),
		.data         (data)
	);

	// ============================================================
	// Helpers
	// ============================================================

	task automatic set_row(input int index, input logic ext, input logic rem,
		input logic [28:0] id, input logic [3:0] dlc_code, input logic draw_random,
		input logic [63:0] payload, input int corruption, input int outcome);
		row_ext[index] = ext;
		row_rem[index] = rem;
		row_id[index] = id;
		row_dlc[index] = dlc_code;
		row_random[index] = draw_random;
		row_data[index] = payload;
		row_corrupt[index] = corruption;
		row_outcome[index] = outcome;
	endtask

	// One bus bit over four clocks, sampled on the fourth edge
	task automatic send_bit(input logic value);
		int phase;
		for (phase = 0; phase < 4; phase++)
		begin
			@(posedge clock);
			if (phase == 0)
				rx_bit <= value;
			sample_point <= (phase == 2);
		end
	endtask

	task automatic compare_field(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected)
		begin
			$display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
			row_failed = 1'b1;
		end
	endtask

	// Frame or error strobe, bounded by the cycle counter
	task automatic wait_outcome();
		while (valid_seen == 0 && error_seen == 0)
			@(posedge clock);
	endtask

	task automatic run_row(input int index);
		logic [63:0] payload;
		logic [63:0] expect_data;
		can_pkg::error_kind_t expect_kind;
		int nbytes;
		int i;
		payload = row_data[index];
		if (row_random[index])
			payload = {$random(seed), $random(seed)};
		build_frame(row_ext[index], row_rem[index], row_id[index], row_dlc[index], payload,
			row_corrupt[index]);
		valid_seen = 0;
		error_seen = 0;
		row_failed = 1'b0;
		for (i = 0; i < line_bits.size(); i++)
			send_bit(line_bits[i]);
		wait_outcome();
		nbytes = row_rem[index] ? 0 : ((row_dlc[index] > 8) ? 8 : row_dlc[index]);
		if (nbytes == 8)
			expect_data = payload;
		else
			expect_data = payload & ((64'd1 << (8 * nbytes)) - 64'd1);   // Right-aligned bytes
		case (row_outcome[index])
			outcome_stuff: expect_kind = can_pkg::error_stuff;
			outcome_crc: expect_kind = can_pkg::error_crc;
			default: expect_kind = can_pkg::error_ack;
		endcase
		if (row_outcome[index] == outcome_frame)
		begin
			compare_field("frame_valid pulses", valid_seen, 1);
			compare_field("frame_error pulses", error_seen, 0);
			compare_field("extended", extended, row_ext[index]);
			compare_field("remote", remote, row_rem[index]);
			if (row_ext[index])
				compare_field("can_id.full", can_id.full, row_id[index]);
			else
			begin
				compare_field("can_id.part.base", can_id.part.base, row_id[index][10:0]);
				compare_field("can_id.part.ext", can_id.part.ext, 0);
			end
			compare_field("dlc", dlc, row_dlc[index]);
			compare_field("data", data, expect_data);
		end
		else
		begin
			compare_field("frame_error pulses", error_seen, 1);
			compare_field("frame_valid pulses", valid_seen, 0);
			compare_field("error_kind", seen_kind, expect_kind);
		end
		if (row_failed)
		begin
			fail_count++;
			$display("Test %0d failed", index);
		end
		else
		begin
			pass_count++;
			$display("Test %0d passed", index);
		end
	endtask

	// ============================================================
	// Monitor and timeout
	// ============================================================

	// Strobes read mid-cycle
	always @(negedge clock)
	begin
		if (frame_valid)
			valid_seen++;
		if (frame_error)
		begin
			error_seen++;
			seen_kind = error_kind;
		end
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: run passed %0d clock cycles before all tests finished",
				cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ============================================================
	// Test sequence
	// ============================================================

	initial
	begin
		reset = 1'b1;
		rx_bit = 1'b1;              // Recessive bus
		sample_point = 1'b0;
		seed = 58;
		cycle_count = 0;
		valid_seen = 0;
		error_seen = 0;
		pass_count = 0;
		fail_count = 0;
		set_row(0, 0, 0, 29'h123, 4'd2, 0, 64'habcd, corrupt_none, outcome_frame);
		set_row(1, 1, 0, 29'h12345678, 4'd15, 1, 64'h0, corrupt_none, outcome_frame);
		set_row(2, 0, 1, 29'h7a5, 4'd4, 0, 64'h0, corrupt_none, outcome_frame);
		set_row(3, 0, 0, 29'h555, 4'd1, 0, 64'h5a, corrupt_stuff, outcome_stuff);
		set_row(4, 1, 0, 29'h0abcdef, 4'd3, 0, 64'h112233, corrupt_none, outcome_frame);
		set_row(5, 0, 0, 29'h0f0, 4'd2, 0, 64'h1234, corrupt_crc, outcome_crc);
		set_row(6, 0, 0, 29'h321, 4'd1, 0, 64'h77, corrupt_ack, outcome_ack);
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		repeat (4) send_bit(1'b1);  // Idle bus before the first frame
		for (row = 0; row < rows; row++)
			run_row(row);
		$display("Tests run %0d, passed %0d, failed %0d", rows, pass_count, fail_count);
		if (fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+test
verilog/can_pkg.sv
verilog/can_destuffer.sv
verilog/can_crc15.sv
verilog/can_frame_parser.sv
verilog/can_decoder.sv
test/can_clock_gen.sv
test/can_decoder_tb.sv

/* Bender.yml */
package:
  name: can_decoder

sources:
  # RTL in compile order
  - files:
      - verilog/can_pkg.sv
      - verilog/can_destuffer.sv
      - verilog/can_crc15.sv
      - verilog/can_frame_parser.sv
      - verilog/can_decoder.sv

  # Testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/can_clock_gen.sv
      - test/can_decoder_tb.sv
